//--- ipu_cfg.svh
// frame size, color thresholds, target size limit, bus address and FIFO depth.
`ifndef IPU_CFG_SVH
`define IPU_CFG_SVH

// frame geometry in pixels.
`define IPU_FRAME_W 16
`define IPU_FRAME_H 12

// 12-bit color thresholds for a target pixel.
`define IPU_R_MIN 12'd2048
`define IPU_G_MAX 12'd1024
`define IPU_B_MAX 12'd1024

`define IPU_MIN_PIXELS 4          // fewer matches means no target.

`define IPU_BUS_BASE 32'h4000_0200 // status register, word aligned.
`define IPU_FIFO_DEPTH 4

`endif

//--- ipu_pkg.sv
// pixel, position, classified pixel, bounding box and frame result types.
`default_nettype none

package ipu_pkg;

    typedef struct packed {
        logic [11:0] r;
        logic [11:0] g;
        logic [11:0] b;
    } rgb_t;

    typedef struct packed {
        logic [9:0] row;
        logic [9:0] col;
    } pos_t;

    typedef struct packed {
        pos_t pos;
        logic match;     // pixel passed the color test.
        logic valid;
        logic frame_end; // last pixel of the frame.
    } class_px_t;

    typedef struct packed {
        logic [9:0] min_row;
        logic [9:0] max_row;
        logic [9:0] min_col;
        logic [9:0] max_col;
    } box_t;

    // one FIFO word per frame.
    typedef struct packed {
        logic present;
        pos_t center;
    } frame_result_t;

endpackage

`default_nettype wire

//--- async_fifo.sv
// dual-clock FIFO with gray-coded pointers and show-ahead read data.
`timescale 1ns/1ps
`default_nettype none

module async_fifo #(
    parameter int WIDTH = 21,
    parameter int DEPTH = 4   // power of two, at least 4.
) (
    input  wire logic             i_wclk,
    input  wire logic             i_wrst_n,
    input  wire logic             i_wr,
    input  wire logic [WIDTH-1:0] i_wdata,
    output logic                  o_full,
    input  wire logic             i_rclk,
    input  wire logic             i_rrst_n,
    input  wire logic             i_rd,
    output logic      [WIDTH-1:0] o_rdata,
    output logic                  o_empty
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW:0] wbin, wgray, rbin, rgray;
    logic [AW:0] rgray_w1, rgray_w2; // read pointer seen by the writer.
    logic [AW:0] wgray_r1, wgray_r2; // write pointer seen by the reader.

    function automatic logic [AW:0] bin2gray(input logic [AW:0] b);
        return b ^ (b >> 1);
    endfunction

    // ====================
    // write side
    // ====================
    assign o_full = (wgray == {~rgray_w2[AW:AW-1], rgray_w2[AW-2:0]});

    always_ff @(posedge i_wclk) begin
        if (i_wr && !o_full)
            mem[wbin[AW-1:0]] <= i_wdata;
    end

    always_ff @(posedge i_wclk, negedge i_wrst_n) begin
        if (!i_wrst_n) begin
            wbin     <= '0;
            wgray    <= '0;
            rgray_w1 <= '0;
            rgray_w2 <= '0;
        end else begin
            rgray_w1 <= rgray;
            rgray_w2 <= rgray_w1;
            if (i_wr && !o_full) begin
                wbin  <= wbin + 1'b1;
                wgray <= bin2gray(wbin + 1'b1);
            end
        end
    end

    // ====================
    // read side
    // ====================
    assign o_empty = (rgray == wgray_r2);
    assign o_rdata = mem[rbin[AW-1:0]]; // valid while not empty.

    always_ff @(posedge i_rclk, negedge i_rrst_n) begin
        if (!i_rrst_n) begin
            rbin     <= '0;
            rgray    <= '0;
            wgray_r1 <= '0;
            wgray_r2 <= '0;
        end else begin
            wgray_r1 <= wgray;
            wgray_r2 <= wgray_r1;
            if (i_rd && !o_empty) begin
                rbin  <= rbin + 1'b1;
                rgray <= bin2gray(rbin + 1'b1);
            end
        end
    end

endmodule

`default_nettype wire

//--- pixel_scanner.sv
// pixel position counters, color classification and frame end marking.
`timescale 1ns/1ps
`default_nettype none
`include "ipu_cfg.svh"

module pixel_scanner (
    input  wire logic              i_cam_clk,
    input  wire logic              i_cam_rst_n,
    input  wire logic              i_dval,
    input  wire ipu_pkg::rgb_t     i_pixel,
    output ipu_pkg::class_px_t     o_px
);

    localparam logic [9:0] LAST_COL = 10'(`IPU_FRAME_W - 1);
    localparam logic [9:0] LAST_ROW = 10'(`IPU_FRAME_H - 1);

    logic [9:0] col_q;
    logic [9:0] row_q;
    logic       last_col;
    logic       is_match;

    assign last_col = (col_q == LAST_COL);
    assign is_match = (i_pixel.r >= `IPU_R_MIN) && (i_pixel.g <= `IPU_G_MAX) &&
                      (i_pixel.b <= `IPU_B_MAX);

    always_ff @(posedge i_cam_clk, negedge i_cam_rst_n) begin
        if (!i_cam_rst_n) begin
            col_q <= '0;
            row_q <= '0;
            o_px  <= '0;
        end else begin
            o_px.valid     <= i_dval;
            o_px.match     <= i_dval && is_match;
            o_px.frame_end <= i_dval && last_col && (row_q == LAST_ROW);
            o_px.pos.row   <= row_q;
            o_px.pos.col   <= col_q;
            if (i_dval) begin // positions step on valid pixels only.
                col_q <= last_col ? '0 : col_q + 1'b1;
                if (last_col)
                    row_q <= (row_q == LAST_ROW) ? '0 : row_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- target_locator.sv
// bounding box of matching pixels over one frame.
`timescale 1ns/1ps
`default_nettype none

module target_locator (
    input  wire logic               i_cam_clk,
    input  wire logic               i_cam_rst_n,
    input  wire ipu_pkg::class_px_t i_px,
    output ipu_pkg::box_t           o_box,
    output logic                    o_any,
    output logic                    o_done
);

    logic          hit;
    logic          any_q;
    ipu_pkg::box_t box_q;
    ipu_pkg::box_t box_nxt;

    assign hit = i_px.valid && i_px.match;

    // fold the current pixel in, the first hit seeds the box.
    always_comb begin
        box_nxt = box_q;
        if (hit) begin
            if (!any_q || i_px.pos.row < box_q.min_row)
                box_nxt.min_row = i_px.pos.row;
            if (!any_q || i_px.pos.row > box_q.max_row)
                box_nxt.max_row = i_px.pos.row;
            if (!any_q || i_px.pos.col < box_q.min_col)
                box_nxt.min_col = i_px.pos.col;
            if (!any_q || i_px.pos.col > box_q.max_col)
                box_nxt.max_col = i_px.pos.col;
        end
    end

    always_ff @(posedge i_cam_clk) begin
        box_q <= box_nxt;
        if (i_px.frame_end)
            o_box <= box_nxt;
    end

    always_ff @(posedge i_cam_clk, negedge i_cam_rst_n) begin
        if (!i_cam_rst_n) begin
            any_q  <= 1'b0;
            o_any  <= 1'b0;
            o_done <= 1'b0;
        end else begin
            o_done <= i_px.frame_end;
            if (i_px.frame_end) begin
                o_any <= any_q || hit;
                any_q <= 1'b0;     // start over for the next frame.
            end else if (hit) begin
                any_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- match_counter.sv
// saturating count of matching pixels per frame.
`timescale 1ns/1ps
`default_nettype none

module match_counter (
    input  wire logic               i_cam_clk,
    input  wire logic               i_cam_rst_n,
    input  wire ipu_pkg::class_px_t i_px,
    output logic [7:0]              o_count,
    output logic                    o_done
);

    logic [7:0] cnt_q;
    logic [7:0] cnt_nxt;

    assign cnt_nxt = (i_px.valid && i_px.match && cnt_q != 8'hff) ? cnt_q + 1'b1 : cnt_q;

    always_ff @(posedge i_cam_clk) begin
        if (i_px.frame_end)
            o_count <= cnt_nxt;
    end

    always_ff @(posedge i_cam_clk, negedge i_cam_rst_n) begin
        if (!i_cam_rst_n) begin
            cnt_q  <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= i_px.frame_end;
            cnt_q  <= i_px.frame_end ? '0 : cnt_nxt;
        end
    end

endmodule

`default_nettype wire

//--- frame_result_merge.sv
// box center and present flag into one FIFO word per frame.
`timescale 1ns/1ps
`default_nettype none
`include "ipu_cfg.svh"

module frame_result_merge (
    input  wire logic                  i_cam_clk,
    input  wire logic                  i_cam_rst_n,
    input  wire ipu_pkg::box_t         i_box,
    input  wire logic                  i_any,
    input  wire logic [7:0]            i_count,
    input  wire logic                  i_done,
    output ipu_pkg::frame_result_t     o_result,
    output logic                       o_wr
);

    logic        present;
    logic [10:0] row_sum;
    logic [10:0] col_sum;

    assign present = i_any && (i_count >= 8'(`IPU_MIN_PIXELS));
    assign row_sum = {1'b0, i_box.min_row} + {1'b0, i_box.max_row};
    assign col_sum = {1'b0, i_box.min_col} + {1'b0, i_box.max_col};

    always_ff @(posedge i_cam_clk) begin
        if (i_done) begin
            o_result.present    <= present;
            o_result.center.row <= present ? row_sum[10:1] : '0; // halved, truncated.
            o_result.center.col <= present ? col_sum[10:1] : '0;
        end
    end

    // one write per frame, full is handled in the FIFO.
    always_ff @(posedge i_cam_clk, negedge i_cam_rst_n) begin
        if (!i_cam_rst_n)
            o_wr <= 1'b0;
        else
            o_wr <= i_done;
    end

endmodule

`default_nettype wire

//--- ipu_bus_slave.sv
// status register with sticky valid and four-phase req/ack bus slave.
`timescale 1ns/1ps
`default_nettype none
`include "ipu_cfg.svh"

module ipu_bus_slave (
    input  wire logic                   sys_clk,
    input  wire logic                   rst_n,
    input  wire ipu_pkg::frame_result_t i_fifo_data,
    input  wire logic                   i_fifo_empty,
    output logic                        o_fifo_rd,
    input  wire logic                   i_bus_req,
    input  wire logic                   i_bus_rd,
    input  wire logic                   i_bus_wr,
    input  wire logic [31:0]            i_bus_addr,
    output logic                        o_bus_ack,
    output logic [31:0]                 o_bus_rdata
);

    localparam logic [31:0] BUS_BASE = `IPU_BUS_BASE;

    ipu_pkg::frame_result_t stat_q;
    logic                   valid_q;
    logic                   hit;
    logic                   req_q;
    logic                   rd_q;
    logic                   ack_rise;

    assign o_fifo_rd = !i_fifo_empty; // drain every word.
    assign hit       = (i_bus_addr[31:2] == BUS_BASE[31:2]) && (i_bus_rd || i_bus_wr);
    assign ack_rise  = req_q && i_bus_req && !o_bus_ack;

    // ====================
    // status register
    // ====================
    always_ff @(posedge sys_clk, negedge rst_n) begin
        if (!rst_n) begin
            stat_q  <= '0;
            valid_q <= 1'b0;
        end else if (o_fifo_rd) begin
            stat_q  <= i_fifo_data;
            valid_q <= 1'b1;     // new result wins over a read clear.
        end else if (ack_rise && rd_q) begin
            valid_q <= 1'b0;
        end
    end

    // ====================
    // bus handshake
    // ====================
    always_ff @(posedge sys_clk, negedge rst_n) begin
        if (!rst_n) begin
            req_q       <= 1'b0;
            rd_q        <= 1'b0;
            o_bus_ack   <= 1'b0;
            o_bus_rdata <= '0;
        end else begin
            req_q <= i_bus_req && hit;
            rd_q  <= i_bus_rd;
            if (!i_bus_req)
                o_bus_ack <= 1'b0;
            else if (ack_rise)
                o_bus_ack <= 1'b1;
            if (ack_rise) // held while ack is high.
                o_bus_rdata <= {10'b0, stat_q.center.row, stat_q.center.col,
                                stat_q.present, valid_q};
        end
    end

endmodule

`default_nettype wire

//--- ipu_top.sv
// image processing unit top, camera domain into sys_clk domain.
`timescale 1ns/1ps
`default_nettype none
`include "ipu_cfg.svh"

module ipu_top (
    input  wire logic              i_cam_clk,
    input  wire logic              i_cam_rst_n,
    input  wire logic              i_dval,
    input  wire ipu_pkg::rgb_t     i_pixel,
    input  wire logic              sys_clk,
    input  wire logic              rst_n,
    input  wire logic              i_bus_req,
    input  wire logic              i_bus_rd,
    input  wire logic              i_bus_wr,
    input  wire logic [31:0]       i_bus_addr,
    output logic                   o_bus_ack,
    output logic [31:0]            o_bus_rdata
);

    ipu_pkg::class_px_t     px;
    ipu_pkg::box_t          box;
    logic                   any;
    logic                   loc_done;
    logic [7:0]             count;
    logic                   cnt_done;
    ipu_pkg::frame_result_t result;
    logic                   result_wr;
    ipu_pkg::frame_result_t fifo_data;
    logic                   fifo_empty;
    logic                   fifo_rd;

    // ====================
    // camera domain
    // ====================
    pixel_scanner u_pixel_scanner (
        .i_cam_clk   (i_cam_clk),
        .i_cam_rst_n (i_cam_rst_n),
        .i_dval      (i_dval),
        .i_pixel     (i_pixel),
        .o_px        (px)
    );

    target_locator u_target_locator (
        .i_cam_clk   (i_cam_clk),
        .i_cam_rst_n (i_cam_rst_n),
        .i_px        (px),
        .o_box       (box),
        .o_any       (any),
        .o_done      (loc_done)
    );

    match_counter u_match_counter (
        .i_cam_clk   (i_cam_clk),
        .i_cam_rst_n (i_cam_rst_n),
        .i_px        (px),
        .o_count     (count),
        .o_done      (cnt_done)
    );

    // both done pulses come from the same frame end.
    frame_result_merge u_frame_result_merge (
        .i_cam_clk   (i_cam_clk),
        .i_cam_rst_n (i_cam_rst_n),
        .i_box       (box),
        .i_any       (any),
        .i_count     (count),
        .i_done      (loc_done && cnt_done),
        .o_result    (result),
        .o_wr        (result_wr)
    );

    async_fifo #(
        .WIDTH ($bits(ipu_pkg::frame_result_t)),
        .DEPTH (`IPU_FIFO_DEPTH)
    ) u_async_fifo (
        .i_wclk   (i_cam_clk),
        .i_wrst_n (i_cam_rst_n),
        .i_wr     (result_wr),
        .i_wdata  (result),
        .o_full   (),        // a result written while full is dropped.
        .i_rclk   (sys_clk),
        .i_rrst_n (rst_n),
        .i_rd     (fifo_rd),
        .o_rdata  (fifo_data),
        .o_empty  (fifo_empty)
    );

    // ====================
    // sys_clk domain
    // ====================
    ipu_bus_slave u_ipu_bus_slave (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .i_fifo_data  (fifo_data),
        .i_fifo_empty (fifo_empty),
        .o_fifo_rd    (fifo_rd),
        .i_bus_req    (i_bus_req),
        .i_bus_rd     (i_bus_rd),
        .i_bus_wr     (i_bus_wr),
        .i_bus_addr   (i_bus_addr),
        .o_bus_ack    (o_bus_ack),
        .o_bus_rdata  (o_bus_rdata)
    );

endmodule

`default_nettype wire

//--- ipu_checker.sv
// status word checker that compares bus read data at each ack rise.
`timescale 1ns/1ps
`default_nettype none

module ipu_checker (
    input wire logic        sys_clk,
    input wire logic        rst_n,
    input wire logic        i_bus_ack,
    input wire logic [31:0] i_bus_rdata
);

    logic ack_q;
    int   mismatches = 0;
    int   compares = 0;

    task automatic compare_field(input string name, input int expected, input int actual);
        if (expected != actual) begin
            mismatches++;
            $display("error at %0t: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
        end
    endtask

    // ====================
    // sampling
    // ====================
    always @(posedge sys_clk) begin
        ack_q <= rst_n ? i_bus_ack : 1'b0;
        // ack rose on the last edge and the data holds while it stays up.
        if (rst_n && i_bus_ack && !ack_q && tb_ipu_top.exp_armed) begin
            if (i_bus_rdata[0] || !tb_ipu_top.exp_valid) begin
                compares++;
                compare_field("valid", int'(tb_ipu_top.exp_valid), int'(i_bus_rdata[0]));
                compare_field("present", int'(tb_ipu_top.exp_present),
                              int'(i_bus_rdata[1]));
                compare_field("col", int'(tb_ipu_top.exp_col), int'(i_bus_rdata[11:2]));
                compare_field("row", int'(tb_ipu_top.exp_row), int'(i_bus_rdata[21:12]));
                compare_field("upper bits", 0, int'(i_bus_rdata[31:22]));
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_ipu_top.sv
// testbench top with clocks, resets, frame painting from the vectors file and bus accesses.
`timescale 1ns/1ps
`default_nettype none
`include "ipu_cfg.svh"

module tb_ipu_top;

    localparam logic [31:0] STATUS_ADDR = `IPU_BUS_BASE;

    logic          sys_clk = 1'b0;
    logic          rst_n;
    logic          cam_clk = 1'b0;
    logic          cam_rst_n;
    logic          dval;
    ipu_pkg::rgb_t pixel;
    logic          bus_req;
    logic          bus_rd;
    logic          bus_wr;
    logic [31:0]   bus_addr;
    logic          bus_ack;
    logic [31:0]   bus_rdata;

    // expected status fields that the checker picks up.
    logic       exp_armed;
    logic       exp_valid;
    logic       exp_present;
    logic [9:0] exp_row;
    logic [9:0] exp_col;

    int tb_fails = 0;
    int reads_expected = 0;
    int frames_sent = 0;
    int results_landed = 0;

    always #10 sys_clk = ~sys_clk;
    always #13 cam_clk = ~cam_clk;   // camera runs on its own clock.

    ipu_top u_ipu_top (
        .i_cam_clk   (cam_clk),
        .i_cam_rst_n (cam_rst_n),
        .i_dval      (dval),
        .i_pixel     (pixel),
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .i_bus_req   (bus_req),
        .i_bus_rd    (bus_rd),
        .i_bus_wr    (bus_wr),
        .i_bus_addr  (bus_addr),
        .o_bus_ack   (bus_ack),
        .o_bus_rdata (bus_rdata)
    );

    ipu_checker u_ipu_checker (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .i_bus_ack   (bus_ack),
        .i_bus_rdata (bus_rdata)
    );

    // one count per word moved from the FIFO into the status register.
    always @(posedge sys_clk) begin
        if (rst_n && u_ipu_top.fifo_rd)
            results_landed <= results_landed + 1;
    end

    // ====================
    // camera side
    // ====================
    task automatic paint_frame(input int r0, input int r1, input int c0, input int c1,
                               input ipu_pkg::rgb_t color, input int gaps);
        int r;
        int c;
        for (r = 0; r < `IPU_FRAME_H; r++) begin
            for (c = 0; c < `IPU_FRAME_W; c++) begin
                if (gaps != 0 && $urandom % 5 == 0) begin
                    repeat (1 + $urandom % 3) begin
                        @(posedge cam_clk);
                        #2;
                        dval  = 1'b0;
                        pixel = color;   // target color on idle cycles must be ignored.
                    end
                end
                @(posedge cam_clk);
                #2;
                dval  = 1'b1;
                pixel = (r >= r0 && r <= r1 && c >= c0 && c <= c1) ? color : '0;
            end
        end
        frames_sent++;
    endtask

    task automatic wait_results_landed();
        int n;
        for (n = 0; n < 200 && results_landed < frames_sent; n++)
            @(posedge sys_clk);
        if (results_landed < frames_sent) begin
            $display("frame result did not reach the status register: %0d of %0d landed",
                     results_landed, frames_sent);
            tb_fails++;
        end
    endtask

    // ====================
    // bus side
    // ====================
    task automatic bus_access(input logic [31:0] addr, input logic wr,
                              output logic [31:0] data, output logic acked);
        int n;
        acked = 1'b0;
        @(posedge sys_clk);
        #2;
        bus_addr = addr;
        bus_rd   = !wr;
        bus_wr   = wr;
        bus_req  = 1'b1;
        for (n = 0; n < 16 && !acked; n++) begin
            @(posedge sys_clk);
            #2;
            acked = bus_ack;
        end
        data    = bus_rdata;
        bus_req = 1'b0;
        bus_rd  = 1'b0;
        bus_wr  = 1'b0;
        for (n = 0; n < 8 && bus_ack; n++) begin
            @(posedge sys_clk);
            #2;
        end
        if (bus_ack) begin
            $display("bus ack stayed high after the request was dropped");
            tb_fails++;
        end
    endtask

    task automatic poll_status();
        logic [31:0] data;
        logic        acked;
        logic        seen;
        int          n;
        seen      = 1'b0;
        acked     = 1'b1;
        exp_valid = 1'b1;
        exp_armed = 1'b1;
        for (n = 0; n < 8 && !seen && acked; n++) begin
            bus_access(STATUS_ADDR, 1'b0, data, acked);
            seen = acked && data[0];
        end
        if (!acked) begin
            $display("status read got no ack while polling");
            tb_fails++;
        end else if (!seen) begin
            $display("status valid bit never set after the frame");
            tb_fails++;
        end else begin
            reads_expected++;
        end
        exp_armed = 1'b0;
    endtask

    // status access that must be acked and return the expected status word.
    task automatic status_access(input logic [31:0] addr, input logic wr, input logic valid);
        logic [31:0] data;
        logic        acked;
        exp_valid = valid;
        exp_armed = 1'b1;
        bus_access(addr, wr, data, acked);
        if (acked) begin
            reads_expected++;
        end else begin
            $display("status access at %h got no ack", addr);
            tb_fails++;
        end
        exp_armed = 1'b0;
    endtask

    task automatic expect_no_ack(input logic [31:0] addr, input logic wr);
        logic [31:0] data;
        logic        acked;
        bus_access(addr, wr, data, acked);
        if (acked) begin
            $display("access at unmapped address %h was acknowledged", addr);
            tb_fails++;
        end
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        int    fd;
        int    n;
        string line;
        int    r0, r1, c0, c1, red, grn, blu, gaps, last, ep, er, ec;
        ipu_pkg::rgb_t color;
        dval        = 1'b0;
        pixel       = '0;
        bus_req     = 1'b0;
        bus_rd      = 1'b0;
        bus_wr      = 1'b0;
        bus_addr    = '0;
        exp_armed   = 1'b0;
        exp_valid   = 1'b0;
        exp_present = 1'b0;
        exp_row     = '0;
        exp_col     = '0;
        rst_n       = 1'b0;
        cam_rst_n   = 1'b0;
        void'($urandom(32'ha2b4_2861));
        fork
            begin
                repeat (10) @(posedge cam_clk);
                #2;
                cam_rst_n = 1'b1;
            end
            begin
                repeat (10) @(posedge sys_clk);
                #2;
                rst_n = 1'b1;
            end
        join
        fd = $fopen("ipu_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open ipu_vectors.txt");
            tb_fails++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == "#")
                    continue;
                n = $sscanf(line, "%d %d %d %d %h %h %h %d %d %d %d %d",
                            r0, r1, c0, c1, red, grn, blu, gaps, last, ep, er, ec);
                if (n != 12) begin
                    $display("malformed line in vectors file: %s", line);
                    tb_fails++;
                    continue;
                end
                color.r = 12'(red);
                color.g = 12'(grn);
                color.b = 12'(blu);
                paint_frame(r0, r1, c0, c1, color, gaps);
                if (last != 0) begin        // a group ends here so read its result back.
                    @(posedge cam_clk);
                    #2;
                    dval        = 1'b0;
                    exp_present = ep[0];
                    exp_row     = 10'(er);
                    exp_col     = 10'(ec);
                    wait_results_landed();
                    status_access(STATUS_ADDR, 1'b1, 1'b1); // a write leaves valid set.
                    poll_status();
                    status_access(STATUS_ADDR, 1'b0, 1'b0);
                end
            end
            $fclose(fd);
        end
        expect_no_ack(STATUS_ADDR + 32'h4, 1'b0);
        expect_no_ack(STATUS_ADDR - 32'h100, 1'b1);
        status_access(STATUS_ADDR, 1'b1, 1'b0);
        status_access(STATUS_ADDR | 32'h2, 1'b0, 1'b0); // low address bits are not decoded.
        if (u_ipu_checker.compares != reads_expected) begin
            $display("checker compared %0d status words but %0d were expected",
                     u_ipu_checker.compares, reads_expected);
            tb_fails++;
        end
        $display("errors: %0d mismatches in %0d compares, %0d testbench failures",
                 u_ipu_checker.mismatches, u_ipu_checker.compares, tb_fails);
        if (tb_fails == 0 && u_ipu_checker.mismatches == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ipu_vectors.txt
# row_lo row_hi col_lo col_hi red green blue (hex) gaps last present row col
# last=1 ends a group of abutting frames, only that frame's result is read back
2 5 3 8 c00 100 080 0 1 1 3 5
0 0 0 2 c00 100 080 0 1 0 0 0
4 7 4 7 7ff 100 100 0 1 0 0 0
4 7 4 7 c00 401 000 0 1 0 0 0
4 7 4 7 c00 000 401 0 1 0 0 0
6 11 10 15 800 400 400 0 1 1 8 12
1 4 9 14 c00 200 000 1 1 1 2 11
0 3 0 3 c00 100 080 0 0 1 1 1
8 10 5 7 c00 100 080 0 1 1 9 6
10 11 14 15 fff 000 000 1 1 1 10 14
0 11 0 15 c00 100 080 1 1 1 5 7

//--- ipu_top.f
+incdir+.
ipu_pkg.sv
async_fifo.sv
pixel_scanner.sv
target_locator.sv
match_counter.sv
frame_result_merge.sv
ipu_bus_slave.sv
ipu_top.sv
ipu_checker.sv
tb_ipu_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the IPU testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_ipu_top -f ipu_top.f -o sim_ipu
./obj_dir/sim_ipu | tee sim.log
if grep -q "Test failures found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
